// File: src/rtc_pkg.sv
package rtc_pkg;

    // DS1302 command bytes, bit 0 selects read
    localparam logic [7:0] addr_sec_wr  = 8'h80;
    localparam logic [7:0] addr_sec_rd  = 8'h81;
    localparam logic [7:0] addr_min_wr  = 8'h82;
    localparam logic [7:0] addr_min_rd  = 8'h83;
    localparam logic [7:0] addr_hour_wr = 8'h84;
    localparam logic [7:0] addr_hour_rd = 8'h85;
    localparam logic [7:0] addr_ctrl_wr = 8'h8E; // write protect in bit 7

    // sec, min, hour
    localparam int num_fields = 3;

    // BCD when setting, binary when returned
    typedef struct packed {
        logic [7:0] sec;
        logic [7:0] min;
        logic [7:0] hour;
    } rtc_time_t;

    // one read byte on its way to the decoders
    typedef struct packed {
        logic       valid;
        logic [1:0] index;
        logic [7:0] bcd;
    } rtc_field_t;

    // engine start levels, at most one bit set
    typedef enum logic [1:0] {
        func_idle  = 2'b00,
        func_read  = 2'b01,
        func_write = 2'b10
    } rtc_func_t;

endpackage

// File: src/ds1302_serial.sv
`timescale 1ns/1ps

module ds1302_serial #(
    parameter int half_period_cycles = 24
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rtc_pkg::rtc_func_t func_start,
    input  logic [7:0]        register_addr,
    input  logic [7:0]        write_data,
    output logic              func_done,
    output logic [7:0]        read_data,
    output logic              rtc_sclk,
    output logic              rtc_ce,
    inout  wire               rtc_sio
);

    localparam int cnt_w = $clog2(half_period_cycles + 2);

    // step 0 setup, 1..32 bit phases (odd low, even high), 33..36 teardown
    localparam logic [5:0] step_setup    = 6'd0;
    localparam logic [5:0] step_first    = 6'd1;
    localparam logic [5:0] step_last_bit = 6'd32;
    localparam logic [5:0] step_sclk_low = 6'd33;
    localparam logic [5:0] step_ce_low   = 6'd34;
    localparam logic [5:0] step_done     = 6'd35;
    localparam logic [5:0] step_hold     = 6'd36;

    logic [cnt_w-1:0] count;
    logic [5:0]       step;
    logic [3:0]       bit_idx;
    logic [15:0]      shift_q;
    logic             active;
    logic             is_read;
    logic             in_bits;
    logic             low_phase;
    logic             half_tick;
    logic             oe;
    logic             sio_q;

    assign active    = func_start != rtc_pkg::func_idle;
    assign is_read   = func_start == rtc_pkg::func_read;
    assign in_bits   = (step >= step_first) && (step <= step_last_bit);
    assign bit_idx   = 4'((step - step_first) >> 1);  // 0..7 address, 8..15 data
    assign low_phase = step[0];
    assign half_tick = count == cnt_w'(half_period_cycles);

    // half-period timer, restarts at every phase boundary
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (active && in_bits && !half_tick)
        begin
            count <= count + 1'b1;
        end
        else
        begin
            count <= '0;
        end
    end

    // address in the low byte, write data in the high byte, sent LSB first
    always_ff @(posedge clk)
    begin
        if (active && step == step_setup)
        begin
            shift_q <= {write_data, register_addr};
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            step      <= step_setup;
            oe        <= 1'b1;
            sio_q     <= 1'b0;
            func_done <= 1'b0;
            read_data <= '0;
            rtc_sclk  <= 1'b0;
            rtc_ce    <= 1'b0;
        end
        else if (!active)
        begin
            // sequencer dropped the request, park the bus
            step      <= step_setup;
            oe        <= 1'b1;
            sio_q     <= 1'b0;
            func_done <= 1'b0;
            rtc_sclk  <= 1'b0;
            rtc_ce    <= 1'b0;
        end
        else if (in_bits)
        begin
            if (low_phase)
            begin
                rtc_sclk <= 1'b0;
                sio_q    <= shift_q[bit_idx];
                // chip drives after the falling edge, sample late in the low phase
                if (half_tick && is_read && bit_idx[3])
                begin
                    read_data[bit_idx[2:0]] <= rtc_sio;
                end
            end
            else
            begin
                rtc_sclk <= 1'b1;
                if (half_tick && is_read && bit_idx == 4'd7)
                begin
                    oe <= 1'b0; // hand sio to the chip after the address byte
                end
            end
            if (half_tick)
            begin
                step <= step + 1'b1;
            end
        end
        else
        begin
            case (step)
                step_setup:
                begin
                    rtc_ce   <= 1'b1;
                    rtc_sclk <= 1'b0;
                    oe       <= 1'b1;
                    step     <= step_first;
                end
                step_sclk_low:
                begin
                    rtc_sclk <= 1'b0;
                    step     <= step_ce_low;
                end
                step_ce_low:
                begin
                    rtc_ce <= 1'b0;
                    step   <= step_done;
                end
                step_done:
                begin
                    func_done <= 1'b1;
                    step      <= step_hold;
                end
                step_hold:
                begin
                    func_done <= 1'b0; // wait here until func_start returns to idle
                end
                default:
                begin
                    step <= step_setup;
                end
            endcase
        end
    end

    assign rtc_sio = oe ? sio_q : 1'bz;

    a_func_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        func_start != 2'b11);

    // chip latches on rising sclk only inside a ce window
    a_sclk_in_ce: assert property (@(posedge clk) disable iff (!rst_n)
        rtc_sclk |-> rtc_ce);

endmodule

// File: src/rtc_sequencer.sv
`timescale 1ns/1ps

module rtc_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                set_time,
    input  rtc_pkg::rtc_time_t  set_value,
    input  logic                read_time,
    input  logic                func_done,
    input  logic [7:0]          read_data,
    output logic                busy,
    output rtc_pkg::rtc_func_t  func_start,
    output logic [7:0]          register_addr,
    output logic [7:0]          write_data,
    output rtc_pkg::rtc_field_t field_bus,
    output logic                read_done
);

    typedef enum logic [1:0] {
        op_idle,
        op_set,
        op_read
    } op_t;

    op_t                op_q;
    logic [1:0]         step_q;
    logic               launch_q;   // start the engine on the next cycle
    rtc_pkg::rtc_time_t set_q;
    logic [7:0]         next_addr;
    logic [7:0]         next_data;
    logic               last_step;
    rtc_pkg::rtc_func_t next_func;

    // register list per operation
    always_comb
    begin
        next_addr = rtc_pkg::addr_sec_rd;
        next_data = 8'h00;
        case (op_q)
            op_set:
            begin
                case (step_q)
                    2'd0: next_addr = rtc_pkg::addr_ctrl_wr; // clear write protect
                    2'd1:
                    begin
                        next_addr = rtc_pkg::addr_sec_wr;
                        next_data = set_q.sec;
                    end
                    2'd2:
                    begin
                        next_addr = rtc_pkg::addr_min_wr;
                        next_data = set_q.min;
                    end
                    default:
                    begin
                        next_addr = rtc_pkg::addr_hour_wr;
                        next_data = set_q.hour;
                    end
                endcase
            end
            op_read:
            begin
                case (step_q)
                    2'd0:    next_addr = rtc_pkg::addr_sec_rd;
                    2'd1:    next_addr = rtc_pkg::addr_min_rd;
                    default: next_addr = rtc_pkg::addr_hour_rd;
                endcase
            end
            default:
            begin
                next_addr = rtc_pkg::addr_sec_rd;
            end
        endcase
    end

    assign last_step = (op_q == op_set) ? (step_q == 2'd3)
                                        : (step_q == 2'(rtc_pkg::num_fields - 1));
    assign next_func = (op_q == op_set) ? rtc_pkg::func_write : rtc_pkg::func_read;

    always_ff @(posedge clk)
    begin
        if (!busy && set_time)
        begin
            set_q <= set_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            op_q          <= op_idle;
            step_q        <= 2'd0;
            launch_q      <= 1'b0;
            busy          <= 1'b0;
            func_start    <= rtc_pkg::func_idle;
            register_addr <= 8'h00;
            write_data    <= 8'h00;
            field_bus     <= '0;
            read_done     <= 1'b0;
        end
        else
        begin
            field_bus.valid <= 1'b0;
            read_done <= field_bus.valid &&
                         (field_bus.index == 2'(rtc_pkg::num_fields - 1));
            if (!busy && (set_time || read_time))
            begin
                op_q     <= set_time ? op_set : op_read; // set wins a tie
                step_q   <= 2'd0;
                launch_q <= 1'b1;
                busy     <= 1'b1;
            end
            else if (launch_q)
            begin
                func_start    <= next_func;
                register_addr <= next_addr;
                write_data    <= next_data;
                launch_q      <= 1'b0;
            end
            else if (func_done)
            begin
                func_start <= rtc_pkg::func_idle;
                if (op_q == op_read)
                begin
                    field_bus.valid <= 1'b1;
                    field_bus.index <= step_q;
                    field_bus.bcd   <= read_data;
                end
                if (last_step)
                begin
                    op_q <= op_idle;
                    busy <= 1'b0;
                end
                else
                begin
                    step_q   <= step_q + 1'b1;
                    launch_q <= 1'b1;
                end
            end
        end
    end

    // engine request must stay put until the engine reports done
    a_start_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (func_start != rtc_pkg::func_idle && !func_done) |=> $stable(func_start));

endmodule

// File: src/bcd_field_decoder.sv
`timescale 1ns/1ps

module bcd_field_decoder #(
    parameter int         field_index = 0,
    parameter logic [7:0] field_mask  = 8'h7F,
    parameter logic [7:0] field_max   = 8'd59
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rtc_pkg::rtc_field_t field_bus,
    output logic [7:0]          value,
    output logic                bad
);

    logic [7:0] masked;
    logic [3:0] tens;
    logic [3:0] units;
    logic [7:0] bin;
    logic       hit;

    assign hit    = field_bus.valid && (field_bus.index == 2'(field_index));
    assign masked = field_bus.bcd & field_mask; // strip CH and mode flags
    assign tens   = masked[7:4];
    assign units  = masked[3:0];
    assign bin    = 8'(tens) * 8'd10 + 8'(units); // max 165, fits

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            value <= 8'h00;
            bad   <= 1'b0;
        end
        else if (hit)
        begin
            value <= bin;
            bad   <= (tens > 4'd9) || (units > 4'd9) || (bin > field_max);
        end
    end

endmodule

// File: src/time_collector.sv
`timescale 1ns/1ps

module time_collector (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   read_done,
    input  logic [rtc_pkg::num_fields-1:0][7:0]    values,
    input  logic [rtc_pkg::num_fields-1:0]         bads,
    output rtc_pkg::rtc_time_t                     time_out,
    output logic                                   time_valid,
    output logic                                   time_error
);

    // field order follows the decoder index
    always_ff @(posedge clk)
    begin
        if (read_done)
        begin
            time_out.sec  <= values[0];
            time_out.min  <= values[1];
            time_out.hour <= values[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            time_valid <= 1'b0;
            time_error <= 1'b0;
        end
        else
        begin
            time_valid <= read_done;
            if (read_done)
            begin
                time_error <= |bads; // held until the next read
            end
        end
    end

    // read_done is a single strobe per read
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        time_valid |=> !time_valid);

endmodule

// File: src/rtc_subsystem.sv
`timescale 1ns/1ps

module rtc_subsystem #(
    parameter int half_period_cycles = 24 // 1 Mbit/s at 50 MHz
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               set_time,
    input  rtc_pkg::rtc_time_t set_value,
    input  logic               read_time,
    output logic               busy,
    output rtc_pkg::rtc_time_t time_out,
    output logic               time_valid,
    output logic               time_error,
    output logic               rtc_sclk,
    output logic               rtc_ce,
    inout  wire                rtc_sio
);

    // index 0 sec, 1 min, 2 hour
    localparam logic [rtc_pkg::num_fields-1:0][7:0] field_mask_tab = {8'h3F, 8'h7F, 8'h7F};
    localparam logic [rtc_pkg::num_fields-1:0][7:0] field_max_tab  = {8'd23, 8'd59, 8'd59};

    rtc_pkg::rtc_func_t                    func_start;
    logic [7:0]                            register_addr;
    logic [7:0]                            write_data;
    logic                                  func_done;
    logic [7:0]                            read_data;
    rtc_pkg::rtc_field_t                   field_bus;
    logic                                  read_done;
    logic [rtc_pkg::num_fields-1:0][7:0]   field_values;
    logic [rtc_pkg::num_fields-1:0]        field_bads;

    ds1302_serial #(
        .half_period_cycles (half_period_cycles)
    ) ds1302_serial_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .func_start    (func_start),
        .register_addr (register_addr),
        .write_data    (write_data),
        .func_done     (func_done),
        .read_data     (read_data),
        .rtc_sclk      (rtc_sclk),
        .rtc_ce        (rtc_ce),
        .rtc_sio       (rtc_sio)
    );

    rtc_sequencer rtc_sequencer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .set_time      (set_time),
        .set_value     (set_value),
        .read_time     (read_time),
        .func_done     (func_done),
        .read_data     (read_data),
        .busy          (busy),
        .func_start    (func_start),
        .register_addr (register_addr),
        .write_data    (write_data),
        .field_bus     (field_bus),
        .read_done     (read_done)
    );

    for (genvar g = 0; g < rtc_pkg::num_fields; g++)
    begin : gen_field
        bcd_field_decoder #(
            .field_index (g),
            .field_mask  (field_mask_tab[g]),
            .field_max   (field_max_tab[g])
        ) bcd_field_decoder_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .field_bus (field_bus),
            .value     (field_values[g]),
            .bad       (field_bads[g])
        );
    end

    time_collector time_collector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_done  (read_done),
        .values     (field_values),
        .bads       (field_bads),
        .time_out   (time_out),
        .time_valid (time_valid),
        .time_error (time_error)
    );

endmodule

// File: test/ds1302_model.sv
`timescale 1ns/1ps

module ds1302_model (
    input  logic       sclk,
    input  logic       ce,
    inout  wire        sio,
    output logic [7:0] reg_sec,
    output logic [7:0] reg_min,
    output logic [7:0] reg_hour
);

    logic        wp = 1'b1;     // write protect set at power-up
    logic [15:0] rx;            // command byte low, data byte high
    logic [4:0]  nbits = 5'd0;  // rising sclk edges in this ce window
    logic [7:0]  tx;
    logic        drive = 1'b0;
    logic        out_bit;

    // register picked by the command byte
    always_comb
    begin
        case (rx[5:1])
            5'd0:    tx = reg_sec;
            5'd1:    tx = reg_min;
            5'd2:    tx = reg_hour;
            default: tx = 8'h00;
        endcase
    end

    always @(posedge sclk or negedge ce)
    begin
        if (!ce)
        begin
            nbits <= 5'd0;
        end
        else if (nbits < 5'd16)
        begin
            rx[nbits[3:0]] <= sio;
            nbits <= nbits + 5'd1;
            // last data bit is still on sio
            if (nbits == 5'd15 && rx[7] && !rx[0])
            begin
                if (rx[5:1] == 5'd7)
                begin
                    wp <= sio; // control register, wp in bit 7
                end
                else if (!wp)
                begin
                    case (rx[5:1])
                        5'd0:    reg_sec  <= {sio, rx[14:8]};
                        5'd1:    reg_min  <= {sio, rx[14:8]};
                        5'd2:    reg_hour <= {sio, rx[14:8]};
                        default: ;
                    endcase
                end
            end
        end
    end

    // read data goes out LSB first after each falling edge
    always @(negedge sclk or negedge ce)
    begin
        if (!ce)
        begin
            drive <= 1'b0;
        end
        else if (rx[0] && nbits >= 5'd8 && nbits < 5'd16)
        begin
            drive   <= 1'b1;
            out_bit <= tx[3'(nbits - 5'd8)];
        end
        else
        begin
            drive <= 1'b0;
        end
    end

    assign sio = drive ? out_bit : 1'bz;

endmodule

// File: test/tb_rtc_subsystem.sv
`timescale 1ns/1ps

module tb_rtc_subsystem;

    localparam int busy_limit  = 6000; // one set takes about 3300 clocks
    localparam int valid_limit = 6000;

    logic               clk;
    logic               rst_n;
    logic               set_time;
    rtc_pkg::rtc_time_t set_value;
    logic               read_time;
    logic               busy;
    rtc_pkg::rtc_time_t time_out;
    logic               time_valid;
    logic               time_error;
    logic               rtc_sclk;
    logic               rtc_ce;
    wire                rtc_sio;
    logic [7:0]         reg_sec;
    logic [7:0]         reg_min;
    logic [7:0]         reg_hour;

    int                 seed = 32'hd6d4;
    logic               op_seen;
    logic               model_check;
    rtc_pkg::rtc_time_t exp_bcd;
    rtc_pkg::rtc_time_t exp_bin;
    logic               exp_err;
    rtc_pkg::rtc_time_t t;
    rtc_pkg::rtc_time_t t_bcd;
    int                 reads_issued;
    int                 valid_count = 0;
    int                 err_idle = 0;
    int                 err_sclk = 0;
    int                 err_model = 0;
    int                 err_result = 0;
    int                 err_valid = 0;
    int                 err_flow = 0;

    rtc_subsystem rtc_subsystem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_time   (set_time),
        .set_value  (set_value),
        .read_time  (read_time),
        .busy       (busy),
        .time_out   (time_out),
        .time_valid (time_valid),
        .time_error (time_error),
        .rtc_sclk   (rtc_sclk),
        .rtc_ce     (rtc_ce),
        .rtc_sio    (rtc_sio)
    );

    ds1302_model ds1302_model_i (
        .sclk     (rtc_sclk),
        .ce       (rtc_ce),
        .sio      (rtc_sio),
        .reg_sec  (reg_sec),
        .reg_min  (reg_min),
        .reg_hour (reg_hour)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        if (time_valid)
        begin
            valid_count <= valid_count + 1;
        end
    end

    // quiet bus between reset release and the first command
    a_idle_after_reset: assert property (@(posedge clk)
        (rst_n && !op_seen) |-> (!busy && !time_valid && !rtc_sclk && !rtc_ce && !rtc_sio))
    else
    begin
        err_idle++;
        $display("bus or status not idle after reset at %0t", $time);
    end

    a_sclk_in_ce: assert property (@(posedge clk) rtc_sclk |-> rtc_ce)
    else
    begin
        err_sclk++;
        $display("rtc_sclk high while rtc_ce low at %0t", $time);
    end

    a_model_regs: assert property (@(posedge clk)
        model_check |-> (reg_sec == exp_bcd.sec && reg_min == exp_bcd.min
                         && reg_hour == exp_bcd.hour))
    else
    begin
        err_model++;
        $display("** Error: reg_sec/reg_min/reg_hour = %h/%h/%h, expected %h/%h/%h",
                 reg_sec, reg_min, reg_hour, exp_bcd.sec, exp_bcd.min, exp_bcd.hour);
    end

    // time_out only compared for in-range reads
    a_result: assert property (@(posedge clk)
        time_valid |-> (time_error == exp_err && (exp_err || time_out == exp_bin)))
    else
    begin
        err_result++;
        $display("** Error: time_out = %h time_error = %h, expected %h %h",
                 time_out, time_error, exp_bin, exp_err);
    end

    a_valid_once: assert property (@(posedge clk) disable iff (!rst_n)
        time_valid |-> (!$past(time_valid) && valid_count < reads_issued))
    else
    begin
        err_valid++;
        $display("time_valid pulse without a matching read at %0t", $time);
    end

    function automatic logic [7:0] to_bcd(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    function automatic rtc_pkg::rtc_time_t time_to_bcd(input rtc_pkg::rtc_time_t b);
        rtc_pkg::rtc_time_t v;
        v.sec  = to_bcd(int'(b.sec));
        v.min  = to_bcd(int'(b.min));
        v.hour = to_bcd(int'(b.hour));
        return v;
    endfunction

    // binary time of day in 24-hour form
    function automatic rtc_pkg::rtc_time_t random_time();
        rtc_pkg::rtc_time_t v;
        v.sec  = 8'({$random(seed)} % 60);
        v.min  = 8'({$random(seed)} % 60);
        v.hour = 8'({$random(seed)} % 24);
        return v;
    endfunction

    task automatic wait_while_busy(input string what);
        int n;
        n = 0;
        while (!busy && n < 8) // busy follows the pulse by one cycle
        begin
            @(posedge clk);
            n++;
        end
        if (!busy)
        begin
            err_flow++;
            $display("busy did not rise after %s", what);
        end
        n = 0;
        while (busy && n < busy_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (busy)
        begin
            err_flow++;
            $display("busy still high %0d clocks after %s", busy_limit, what);
        end
    endtask

    task automatic set_and_verify(input rtc_pkg::rtc_time_t v);
        set_value <= v;
        set_time  <= 1'b1;
        exp_bcd   <= v;
        op_seen   <= 1'b1;
        @(posedge clk);
        set_time <= 1'b0;
        wait_while_busy("set_time");
        model_check <= 1'b1; // chip registers compared on the next edge
        @(posedge clk);
        model_check <= 1'b0;
    endtask

    task automatic read_and_verify(input rtc_pkg::rtc_time_t v, input logic err,
                                   input logic poke);
        int n;
        exp_bin      <= v;
        exp_err      <= err;
        read_time    <= 1'b1;
        reads_issued <= reads_issued + 1;
        @(posedge clk);
        read_time <= 1'b0;
        if (poke)
        begin
            @(posedge clk);
            @(posedge clk);
            read_time <= 1'b1; // lands while busy
            @(posedge clk);
            read_time <= 1'b0;
        end
        n = 0;
        while (!time_valid && n < valid_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (!time_valid)
        begin
            err_flow++;
            $display("no time_valid within %0d clocks of read_time", valid_limit);
        end
        @(posedge clk);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        set_time     = 1'b0;
        set_value    = '0;
        read_time    = 1'b0;
        op_seen      = 1'b0;
        model_check  = 1'b0;
        exp_bcd      = '0;
        exp_bin      = '0;
        exp_err      = 1'b0;
        reads_issued = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        repeat (3)
        begin
            t = random_time();
            set_and_verify(time_to_bcd(t));
            read_and_verify(t, 1'b0, 1'b0);
        end

        // clock-halt flag kept by the chip and dropped by the decoder
        t         = random_time();
        t_bcd     = time_to_bcd(t);
        t_bcd.sec = t_bcd.sec | 8'h80;
        set_and_verify(t_bcd);
        read_and_verify(t, 1'b0, 1'b0);

        t_bcd     = time_to_bcd(random_time());
        t_bcd.min = 8'h7A;
        set_and_verify(t_bcd);
        read_and_verify('0, 1'b1, 1'b0);

        t_bcd      = time_to_bcd(random_time());
        t_bcd.hour = 8'h24;
        set_and_verify(t_bcd);
        read_and_verify('0, 1'b1, 1'b1);
        repeat (3000) @(posedge clk); // room for a stray read to show up

        a_all_reads: assert (valid_count == reads_issued)
        else
        begin
            err_flow++;
            $display("%0d time_valid pulses for %0d reads", valid_count, reads_issued);
        end
        $display("errors: idle %0d sclk %0d model %0d result %0d valid %0d flow %0d",
                 err_idle, err_sclk, err_model, err_result, err_valid, err_flow);
        if (err_idle + err_sclk + err_model + err_result + err_valid + err_flow == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
src/rtc_pkg.sv
src/ds1302_serial.sv
src/rtc_sequencer.sv
src/bcd_field_decoder.sv
src/time_collector.sv
src/rtc_subsystem.sv
test/ds1302_model.sv
test/tb_rtc_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rtc_subsystem -f compile.f

output=$(./obj_dir/Vtb_rtc_subsystem)
echo "$output"
grep -q "TEST PASSED" <<< "$output"
